// ==== src/fan_ctrl_pkg.sv ====
package fan_ctrl_pkg;

    // Control field width per lane line.
    localparam int DW_CTRL = 4;

    typedef logic [DW_CTRL-1:0] ctrl_t;

    // Line carries a value.
    localparam int CTRL_LIVE = 3;

    // Bit 2 is spare and stays zero.

    // Segment's last product is inside this line.
    localparam int CTRL_END = 1;

    // Segment's first product is inside this line.
    localparam int CTRL_START = 0;

    // A line with LIVE, START and END set holds a finished row sum.

endpackage

// ==== src/fan_types_pkg.sv ====
package fan_types_pkg;

    // Lanes per beat.
    localparam int N_LANES = 4;

    // Operand, product and sum width.
    localparam int DW_DATA = 8;

    // Row id width.
    localparam int DW_ROW = 4;

    // One lane line holds ctrl, row and data from the high bits down.
    localparam int DW_LINE = DW_DATA + DW_ROW + fan_ctrl_pkg::DW_CTRL;

    // Enough bits to count 0 to N_LANES sums.
    localparam int DW_CNT = $clog2(N_LANES + 1);

    typedef logic [DW_DATA-1:0] data_t;

    typedef logic [DW_ROW-1:0] row_t;

    typedef logic [DW_LINE-1:0] line_t;

    typedef logic [DW_CNT-1:0] cnt_t;

endpackage

// ==== src/product_stage.sv ====
`timescale 1ns/1ps

module product_stage
    import fan_types_pkg::*;
    import fan_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  data_t [N_LANES-1:0]   in_a,
    input  data_t [N_LANES-1:0]   in_b,
    input  row_t  [N_LANES-1:0]   in_row,
    input  logic  [N_LANES-1:0]   in_en,
    output logic                  out_valid,
    input  logic                  out_ready,
    output line_t [N_LANES-1:0]   out_line
);

    // link[i] set when lane i continues the segment of lane i-1.
    logic  [N_LANES:0]   link;
    line_t [N_LANES-1:0] line_next;

    always_comb begin
        link = '0;
        for (int i = 1; i < N_LANES; i++) begin
            link[i] = in_en[i-1] && in_en[i] && (in_row[i-1] == in_row[i]);
        end
    end

    always_comb begin
        ctrl_t ctrl;
        data_t prod;
        for (int i = 0; i < N_LANES; i++) begin
            ctrl = '0;
            prod = data_t'(in_a[i] * in_b[i]);
            if (in_en[i]) begin
                ctrl[CTRL_LIVE]  = 1'b1;
                ctrl[CTRL_START] = !link[i];
                ctrl[CTRL_END]   = !link[i+1];
                line_next[i] = {ctrl, in_row[i], prod};
            end else begin
                // Disabled lanes carry nothing.
                line_next[i] = '0;
            end
        end
    end

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_line <= line_next;
        end
    end

endmodule

// ==== src/fan_pair_stage.sv ====
`timescale 1ns/1ps

module fan_pair_stage
    import fan_types_pkg::*;
    import fan_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  line_t [N_LANES-1:0]   in_line,
    output logic                  out_valid,
    input  logic                  out_ready,
    output line_t [N_LANES-1:0]   out_line
);

    ctrl_t [N_LANES-1:0] ctrl;
    row_t  [N_LANES-1:0] row;
    logic                merge_lo;
    logic                merge_hi;
    line_t [N_LANES-1:0] line_next;

    // Sum of two adjacent lines where lo is the lower lane.
    function automatic line_t merge_pair(line_t lo, line_t hi);
        ctrl_t lo_ctrl;
        ctrl_t hi_ctrl;
        row_t  lo_row;
        data_t lo_data;
        data_t hi_data;
        ctrl_t ctrl_sum;
        {lo_ctrl, lo_row, lo_data} = lo;
        hi_ctrl = hi[DW_LINE-1 -: DW_CTRL];
        hi_data = hi[DW_DATA-1:0];
        ctrl_sum = '0;
        ctrl_sum[CTRL_LIVE]  = 1'b1;
        ctrl_sum[CTRL_START] = lo_ctrl[CTRL_START];
        ctrl_sum[CTRL_END]   = hi_ctrl[CTRL_END];
        return {ctrl_sum, lo_row, data_t'(lo_data + hi_data)};
    endfunction

    always_comb begin
        for (int i = 0; i < N_LANES; i++) begin
            ctrl[i] = in_line[i][DW_LINE-1 -: DW_CTRL];
            row[i]  = in_line[i][DW_DATA +: DW_ROW];
        end
    end

    assign merge_lo = ctrl[0][CTRL_LIVE] && ctrl[1][CTRL_LIVE] && (row[0] == row[1]);
    assign merge_hi = ctrl[2][CTRL_LIVE] && ctrl[3][CTRL_LIVE] && (row[2] == row[3]);

    // Merged sums land on the inner lanes 1 and 2.
    always_comb begin
        line_next = in_line;
        if (merge_lo) begin
            line_next[0] = '0;
            line_next[1] = merge_pair(in_line[0], in_line[1]);
        end
        if (merge_hi) begin
            line_next[2] = merge_pair(in_line[2], in_line[3]);
            line_next[3] = '0;
        end
    end

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_line <= line_next;
        end
    end

endmodule

// ==== src/fan_adder_4to4.sv ====
`timescale 1ns/1ps

module fan_adder_4to4
    import fan_types_pkg::*;
    import fan_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  line_t [N_LANES-1:0]   in_line,
    output logic                  out_valid,
    input  logic                  out_ready,
    output line_t [N_LANES-1:0]   out_line
);

    ctrl_t [N_LANES-1:0] in_ctrl;
    row_t  [N_LANES-1:0] in_rid;
    data_t [N_LANES-1:0] in_data;

    logic                both_live;
    logic                same_row;
    logic                merge;
    ctrl_t               merge_ctrl;
    data_t               merge_data;
    line_t [N_LANES-1:0] line_next;

    always_comb begin
        for (int i = 0; i < N_LANES; i++) begin
            {in_ctrl[i], in_rid[i], in_data[i]} = in_line[i];
        end
    end

    // Only the two middle lanes can still meet at this level.
    assign both_live = in_ctrl[1][CTRL_LIVE] && in_ctrl[2][CTRL_LIVE];
    assign same_row  = in_rid[1] == in_rid[2];
    assign merge     = both_live && same_row;

    // Lane 1 holds the lower part of the segment.
    always_comb begin
        merge_ctrl = '0;
        merge_ctrl[CTRL_LIVE]  = 1'b1;
        merge_ctrl[CTRL_START] = in_ctrl[1][CTRL_START];
        merge_ctrl[CTRL_END]   = in_ctrl[2][CTRL_END];
    end

    assign merge_data = in_data[1] + in_data[2];

    always_comb begin
        if (merge) begin
            line_next[0] = in_line[0];
            line_next[1] = {merge_ctrl, in_rid[1], merge_data};
            line_next[2] = '0;
            line_next[3] = in_line[3];
        end else begin
            // Row mismatch or a dead lane.
            line_next = in_line;
        end
    end

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_line <= line_next;
        end
    end

endmodule

// ==== src/sum_emit_stage.sv ====
`timescale 1ns/1ps

module sum_emit_stage
    import fan_types_pkg::*;
    import fan_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  line_t [N_LANES-1:0]   in_line,
    output logic                  out_valid,
    input  logic                  out_ready,
    output cnt_t                  out_count,
    output row_t  [N_LANES-1:0]   out_row,
    output data_t [N_LANES-1:0]   out_sum
);

    ctrl_t [N_LANES-1:0] ctrl;
    row_t  [N_LANES-1:0] row;
    data_t [N_LANES-1:0] data;
    logic  [N_LANES-1:0] done;
    cnt_t                count_next;
    row_t  [N_LANES-1:0] row_next;
    data_t [N_LANES-1:0] sum_next;

    always_comb begin
        for (int i = 0; i < N_LANES; i++) begin
            {ctrl[i], row[i], data[i]} = in_line[i];
            done[i] = ctrl[i][CTRL_LIVE] && ctrl[i][CTRL_START] && ctrl[i][CTRL_END];
        end
    end

    // Finished sums go to the lowest free slot in lane order.
    always_comb begin
        cnt_t pos;
        pos = '0;
        row_next = '0;
        sum_next = '0;
        for (int i = 0; i < N_LANES; i++) begin
            if (done[i]) begin
                for (int j = 0; j < N_LANES; j++) begin
                    if (pos == cnt_t'(j)) begin
                        row_next[j] = row[i];
                        sum_next[j] = data[i];
                    end
                end
                pos = pos + 1'b1;
            end
        end
        count_next = pos;
    end

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_count <= count_next;
            out_row   <= row_next;
            out_sum   <= sum_next;
        end
    end

endmodule

// ==== src/fan_reduce_top.sv ====
`timescale 1ns/1ps

module fan_reduce_top
    import fan_types_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  data_t [N_LANES-1:0]   in_a,
    input  data_t [N_LANES-1:0]   in_b,
    input  row_t  [N_LANES-1:0]   in_row,
    input  logic  [N_LANES-1:0]   in_en,
    output logic                  out_valid,
    input  logic                  out_ready,
    output cnt_t                  out_count,
    output row_t  [N_LANES-1:0]   out_row,
    output data_t [N_LANES-1:0]   out_sum
);

    logic                prod_valid;
    logic                prod_ready;
    line_t [N_LANES-1:0] prod_line;

    logic                pair_valid;
    logic                pair_ready;
    line_t [N_LANES-1:0] pair_line;

    logic                mid_valid;
    logic                mid_ready;
    line_t [N_LANES-1:0] mid_line;

    product_stage product_stage_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_a      (in_a),
        .in_b      (in_b),
        .in_row    (in_row),
        .in_en     (in_en),
        .out_valid (prod_valid),
        .out_ready (prod_ready),
        .out_line  (prod_line)
    );

    // First adder level on pairs 0-1 and 2-3.
    fan_pair_stage fan_pair_stage_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (prod_valid),
        .in_ready  (prod_ready),
        .in_line   (prod_line),
        .out_valid (pair_valid),
        .out_ready (pair_ready),
        .out_line  (pair_line)
    );

    // Second adder level on lanes 1 and 2.
    fan_adder_4to4 fan_adder_4to4_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (pair_valid),
        .in_ready  (pair_ready),
        .in_line   (pair_line),
        .out_valid (mid_valid),
        .out_ready (mid_ready),
        .out_line  (mid_line)
    );

    sum_emit_stage sum_emit_stage_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (mid_valid),
        .in_ready  (mid_ready),
        .in_line   (mid_line),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_count (out_count),
        .out_row   (out_row),
        .out_sum   (out_sum)
    );

endmodule

// ==== tb/tb_fan_reduce.sv ====
`timescale 1ns/1ps

module tb_fan_reduce
    import fan_types_pkg::*;
#(
    parameter int SEED = 59193
);

    localparam int MAX_CASES = 64;
    localparam int TIMEOUT   = 200;
    localparam int N_FIELDS  = 22;
    localparam int SNAP_W    = DW_CNT + N_LANES * (DW_ROW + DW_DATA);

    logic                clk;
    logic                rst;
    logic                in_valid;
    logic                in_ready;
    data_t [N_LANES-1:0] in_a;
    data_t [N_LANES-1:0] in_b;
    row_t  [N_LANES-1:0] in_row;
    logic  [N_LANES-1:0] in_en;
    logic                out_valid;
    logic                out_ready;
    cnt_t                out_count;
    row_t  [N_LANES-1:0] out_row;
    data_t [N_LANES-1:0] out_sum;

    // One entry per beat from the case file.
    data_t [N_LANES-1:0] case_a   [MAX_CASES];
    data_t [N_LANES-1:0] case_b   [MAX_CASES];
    row_t  [N_LANES-1:0] case_row [MAX_CASES];
    logic  [N_LANES-1:0] case_en  [MAX_CASES];
    cnt_t                exp_cnt  [MAX_CASES];
    row_t  [N_LANES-1:0] exp_row  [MAX_CASES];
    data_t [N_LANES-1:0] exp_sum  [MAX_CASES];
    int                  n_cases;

    // Case indices of accepted input beats with the oldest first.
    int exp_q [$];

    int                cycle = 0;
    int                first_in_cycle = 0;
    logic              bp_on = 1'b0;
    logic              hold_seen = 1'b0;
    logic [SNAP_W-1:0] hold_snap;

    fan_reduce_top fan_reduce_top_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_a      (in_a),
        .in_b      (in_b),
        .in_row    (in_row),
        .in_en     (in_en),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_count (out_count),
        .out_row   (out_row),
        .out_sum   (out_sum)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Ready drops on about 30 percent of cycles while back-pressure is on.
    initial begin
        void'($urandom(SEED));
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            if (bp_on) begin
                out_ready <= ($urandom % 100) >= 30;
            end else begin
                out_ready <= 1'b1;
            end
        end
    end

    // A stalled output beat must not change.
    always @(posedge clk) begin
        if (!rst && hold_seen) begin
            assert (out_valid && {out_count, out_row, out_sum} == hold_snap)
                else stop_run($sformatf("FAILED at %0t: output changed while stalled", $time));
        end
        hold_seen <= out_valid && !out_ready;
        hold_snap <= {out_count, out_row, out_sum};
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped after an error");
    endtask

    task automatic load_cases();
        int          fd;
        int          got;
        string       line;
        logic [31:0] f [N_FIELDS];
        fd = $fopen("tb/fan_cases.txt", "r");
        if (fd == 0) begin
            stop_run("cannot open tb/fan_cases.txt");
        end
        n_cases = 0;
        while (!$feof(fd)) begin
            got = $fgets(line, fd);
            if (got > 1 && line[0] != "#") begin
                got = $sscanf(line, "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                              f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                              f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15],
                              f[16], f[17], f[18], f[19], f[20], f[21]);
                if (got != N_FIELDS) begin
                    stop_run("malformed line in tb/fan_cases.txt");
                end
                if (n_cases == MAX_CASES) begin
                    stop_run("too many cases in tb/fan_cases.txt");
                end
                for (int i = 0; i < N_LANES; i++) begin
                    case_a[n_cases][i]   = data_t'(f[1 + 3*i]);
                    case_b[n_cases][i]   = data_t'(f[2 + 3*i]);
                    case_row[n_cases][i] = row_t'(f[3 + 3*i]);
                    exp_row[n_cases][i]  = row_t'(f[14 + i]);
                    exp_sum[n_cases][i]  = data_t'(f[18 + i]);
                end
                case_en[n_cases] = f[0][N_LANES-1:0];
                exp_cnt[n_cases] = cnt_t'(f[13]);
                n_cases++;
            end
        end
        $fclose(fd);
        if (n_cases == 0) begin
            stop_run("no cases found in tb/fan_cases.txt");
        end
    endtask

    // Pushes every case back to back with one beat per accepted transfer.
    task automatic drive_cases(input bit mark_first);
        int waited;
        for (int k = 0; k < n_cases; k++) begin
            in_valid <= 1'b1;
            in_a     <= case_a[k];
            in_b     <= case_b[k];
            in_row   <= case_row[k];
            in_en    <= case_en[k];
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
                if (waited > TIMEOUT) begin
                    stop_run("timeout waiting for in_ready");
                end
            end while (!in_ready);
            exp_q.push_back(k);
            if (mark_first && k == 0) begin
                first_in_cycle = cycle;
            end
        end
        in_valid <= 1'b0;
    endtask

    task automatic check_beat(input int idx);
        assert (out_count == exp_cnt[idx])
            else stop_run($sformatf("FAILED at %0t: case %0d out_count %0d, expected %0d",
                                    $time, idx, out_count, exp_cnt[idx]));
        for (int i = 0; i < N_LANES; i++) begin
            assert (out_row[i] == exp_row[idx][i])
                else stop_run($sformatf("FAILED at %0t: case %0d out_row[%0d] %h, expected %h",
                                        $time, idx, i, out_row[i], exp_row[idx][i]));
            assert (out_sum[i] == exp_sum[idx][i])
                else stop_run($sformatf("FAILED at %0t: case %0d out_sum[%0d] %h, expected %h",
                                        $time, idx, i, out_sum[i], exp_sum[idx][i]));
        end
    endtask

    task automatic collect_results(input bit check_latency);
        int waited;
        int idx;
        for (int k = 0; k < n_cases; k++) begin
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
                if (waited > TIMEOUT) begin
                    stop_run("timeout waiting for an output beat");
                end
            end while (!(out_valid && out_ready));
            assert (exp_q.size() > 0)
                else stop_run("output beat arrived with no input beat outstanding");
            idx = exp_q.pop_front();
            if (check_latency && k == 0) begin
                assert (cycle - first_in_cycle == 4)
                    else stop_run($sformatf("FAILED at %0t: latency %0d cycles, expected 4",
                                            $time, cycle - first_in_cycle));
            end
            check_beat(idx);
        end
    endtask

    initial begin
        int start_cycle;
        rst      = 1'b1;
        in_valid = 1'b0;
        in_a     = '0;
        in_b     = '0;
        in_row   = '0;
        in_en    = '0;
        load_cases();
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        assert (in_ready) else stop_run("in_ready is low after reset release");

        // Ready held high, so the run must take one cycle per beat plus the latency.
        start_cycle = cycle;
        fork
            drive_cases(1'b1);
            collect_results(1'b1);
        join
        assert (cycle - start_cycle == n_cases + 4)
            else stop_run($sformatf("FAILED at %0t: %0d cycles for %0d beats, expected %0d",
                                    $time, cycle - start_cycle, n_cases, n_cases + 4));

        bp_on <= 1'b1;
        fork
            drive_cases(1'b0);
            collect_results(1'b0);
        join

        repeat (8) begin
            @(posedge clk);
            assert (!out_valid) else stop_run("extra output beat after the last case");
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== tb/fan_cases.txt ====
# en a0 b0 r0 a1 b1 r1 a2 b2 r2 a3 b3 r3 | count row0 row1 row2 row3 sum0 sum1 sum2 sum3
# All fields hex, bit i of en enables lane i, unused output lanes are zero.
f 03 04 1 05 06 2 07 08 3 09 0a 4 4 1 2 3 4 0c 1e 38 5a
f 10 10 0 11 11 5 ff 02 6 80 03 7 4 0 5 6 7 00 21 fe 80
f 0f 0f 9 02 7f 3 20 09 a 0d 0d c 4 9 3 a c e1 fe 20 a9
f 01 02 5 03 04 5 05 06 5 07 08 5 1 5 0 0 0 64 00 00 00
f 10 10 f 20 08 f ff ff f 0c 0c f 1 f 0 0 0 91 00 00 00
f 7f 02 0 7f 02 0 7f 02 0 7f 02 0 1 0 0 0 0 f8 00 00 00
f 03 03 1 04 04 2 05 05 2 06 06 3 3 1 2 3 0 09 29 24 00
f 02 03 4 0a 0a 8 0b 0b 8 0c 0c 8 2 4 8 0 0 06 6d 00 00
f 02 02 6 03 03 6 04 04 6 05 05 7 2 6 7 0 0 1d 19 00 00
f 01 05 a 02 05 a 03 05 b 04 05 b 2 a b 0 0 0f 23 00 00
f 11 02 1 01 01 1 30 05 2 09 09 3 3 1 2 3 0 23 f0 51 00
f 06 07 1 08 09 2 0a 0b 3 0c 0d 3 3 1 2 3 0 2a 48 0a 00
f ff 01 9 ff 01 9 02 01 9 01 01 1 2 9 1 0 0 00 01 00 00
e 55 55 2 02 02 2 02 03 2 02 04 2 1 2 0 0 0 12 00 00 00
0 00 00 0 00 00 0 00 00 0 00 00 0 0 0 0 0 0 00 00 00 00
5 04 05 3 09 09 3 06 06 3 07 07 3 2 3 3 0 0 14 24 00 00
a 21 03 4 05 05 4 33 02 5 03 07 5 2 4 5 0 0 19 15 00 00
8 11 11 6 22 22 6 33 33 6 0e 0e 6 1 6 0 0 0 c4 00 00 00
1 ff ff 7 01 02 7 03 04 7 05 06 7 1 7 0 0 0 01 00 00 00
b 02 03 2 04 05 2 06 07 2 03 03 2 2 2 2 0 0 1a 09 00 00
0 12 34 5 56 78 6 9a bc 7 de f0 8 0 0 0 0 0 00 00 00 00
6 40 40 8 10 02 8 10 03 8 40 40 8 1 8 0 0 0 50 00 00 00
7 01 01 1 02 02 1 03 03 1 04 04 1 1 1 0 0 0 0e 00 00 00
d 05 03 3 77 77 4 08 08 4 02 20 4 2 3 4 0 0 0f 80 00 00
f 80 01 1 80 01 1 c0 01 2 41 01 2 2 1 2 0 0 00 01 00 00
f 10 01 e 20 01 e 30 01 e 40 01 f 2 e f 0 0 60 40 00 00
f 01 01 3 02 01 2 03 01 1 04 01 0 4 3 2 1 0 01 02 03 04
e 99 99 4 c8 01 5 64 01 5 01 01 5 1 5 0 0 0 2d 00 00 00
f 03 05 7 05 03 7 0a 0a 8 0a 0a 8 2 7 8 0 0 1e c8 00 00
3 11 11 9 02 02 9 03 03 9 04 04 9 1 9 0 0 0 25 00 00 00
c 05 05 a 06 06 a 0f 11 a 01 01 a 1 a 0 0 0 00 00 00 00
f 07 07 2 08 08 3 09 09 3 0a 03 4 3 2 3 4 0 31 91 1e 00

// ==== vlog.f ====
src/fan_ctrl_pkg.sv
src/fan_types_pkg.sv
src/product_stage.sv
src/fan_pair_stage.sv
src/fan_adder_4to4.sv
src/sum_emit_stage.sv
src/fan_reduce_top.sv
tb/tb_fan_reduce.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_fan_reduce
SEED      ?= 59193
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0

COMMON_FLAGS = --timing --timescale 1ns/1ps -f $(FILELIST) --top-module $(TOP)
SIM_FLAGS   ?= --binary --assert -j $(JOBS)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(COMMON_FLAGS)

# The simulation binary exits non-zero on $fatal, so make fails with it.
sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON_FLAGS) -GSEED=$(SEED) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
